// File: build.f
cart_pkg.sv
cart_bank_table.sv
cart_mapper_ctrl.sv
cart_addr_xlate.sv
cartridge.sv
cartridge_asserts.sv
tb_cartridge.sv

// File: cart_addr_xlate.sv
// Address translation: maps ROML, ROMH and IO window accesses onto the SDRAM CRT image
`timescale 1ns/10ps

module cart_addr_xlate (
	input  logic                              reset_n,	// Synchronous, active high
	input  logic                              rom_l,
	input  logic                              rom_h,
	input  logic                              ioe,
	input  logic                              iof,
	input  logic                              mem_write,
	input  logic                              mem_ce,
	input  logic                              stb_ioe,
	input  logic                              stb_iof,
	input  logic                              ioe_ena,
	input  logic                              iof_ena,
	input  logic                              ioe_wr_ena,
	input  logic                              iof_wr_ena,
	input  logic                              exrom_ov,
	input  logic                              game_ov,
	input  logic [15:0]                       addr_in,
	input  logic [cart_pkg::bank_w-1:0]       bank_lo,
	input  logic [cart_pkg::bank_w-1:0]       bank_hi,
	input  logic [cart_pkg::bank_w-1:0]       ioe_bank,
	input  logic [cart_pkg::bank_w-1:0]       iof_bank,
	output logic [cart_pkg::sdram_addr_w-1:0] addr_out,
	output logic                              mem_ce_out,
	output logic                              mem_write_out
);

	logic cs_ioe;
	logic cs_iof;

	// SDRAM bank field for a cartridge bank, RAM uses the low 3 bits only
	function automatic logic [cart_pkg::sdram_bank_w-1:0] bank_field(
		input logic [cart_pkg::bank_w-1:0] bank,
		input logic                        ram
	);
		if (ram)
			bank_field = cart_pkg::ram_region_base
				| {{(cart_pkg::sdram_bank_w-3){1'b0}}, bank[2:0]};
		else
			bank_field = cart_pkg::rom_region_bit
				| {{(cart_pkg::sdram_bank_w-cart_pkg::bank_w){1'b0}}, bank};
	endfunction

	// IO window enabled for this direction
	assign cs_ioe = ioe && (mem_write ? ioe_wr_ena : ioe_ena);
	assign cs_iof = iof && (mem_write ? iof_wr_ena : iof_ena);

	assign mem_ce_out = mem_ce || (cs_ioe && stb_ioe) || (cs_iof && stb_iof);

	// No RAM exists under ROML in ultimax mode
	assign mem_write_out = mem_write && !(rom_l && exrom_ov && !game_ov);

	always_comb begin
		addr_out = {{(cart_pkg::sdram_addr_w-16){1'b0}}, addr_in};

		// No remapping while the cartridge is held in reset
		if (!reset_n) begin
			if (rom_h && !mem_write)
				addr_out[cart_pkg::sdram_addr_w-1:13] = bank_field(bank_hi, 1'b0);
			if (rom_l && !mem_write)
				addr_out[cart_pkg::sdram_addr_w-1:13] = bank_field(bank_lo, 1'b0);

			if (cs_ioe)
				addr_out[cart_pkg::sdram_addr_w-1:13] = bank_field(ioe_bank, ioe_wr_ena);
			if (cs_iof)
				addr_out[cart_pkg::sdram_addr_w-1:13] = bank_field(iof_bank, iof_wr_ena);	// $DFxx wins
		end
	end

endmodule

// File: cart_bank_table.sv
// Bank table: records the SDRAM bank of each CRT chip packet during load and serves lookups
`timescale 1ns/10ps

module cart_bank_table (
	input  logic                           clk32,
	input  logic                           cart_loading,
	input  logic                           cart_bank_wr,	// One strobe per chip packet
	input  logic [15:0]                    cart_bank_laddr,
	input  logic [15:0]                    cart_bank_size,
	input  logic [15:0]                    cart_bank_num,
	input  logic [cart_pkg::sdram_addr_w-1:0] cart_bank_raddr,
	input  logic [cart_pkg::sel_w-1:0]     sel_bank,
	output logic [cart_pkg::bank_w-1:0]    sel_lo,
	output logic [cart_pkg::bank_w-1:0]    sel_hi,
	output logic [cart_pkg::bank_w-1:0]    lo_entry0,
	output logic [cart_pkg::bank_w-1:0]    hi_entry0
);

	// ROML and ROMH bank per chip packet
	logic [cart_pkg::bank_w-1:0] lo_banks [cart_pkg::table_depth];
	logic [cart_pkg::bank_w-1:0] hi_banks [cart_pkg::table_depth];

	logic       old_loading;
	logic [7:0] bank_cnt;		// Packets seen since load start
	logic [cart_pkg::bank_w-1:0] raw_bank;
	logic [cart_pkg::sel_w-1:0]  slot;
	logic       accept;

	assign raw_bank = cart_bank_raddr[13 +: cart_pkg::bank_w];
	assign slot     = cart_bank_num[cart_pkg::sel_w-1:0];

	// Counter saturates, so a runaway loader cannot wrap into the table
	assign accept = cart_bank_wr && (cart_bank_num < cart_pkg::table_depth) && (bank_cnt != 8'hFF);

	always_ff @(posedge clk32) begin
		old_loading <= cart_loading;
		if (!old_loading && cart_loading) begin
			bank_cnt <= 8'd0;					// New image
		end else if (cart_bank_wr && bank_cnt != 8'hFF) begin
			bank_cnt <= bank_cnt + 8'd1;
		end
	end

	always_ff @(posedge clk32) begin
		if (accept) begin
			if (cart_bank_laddr <= cart_pkg::low_load_limit) begin
				lo_banks[slot] <= raw_bank;
				// 16 KB packet, upper half follows in the next bank
				if (cart_bank_size > cart_pkg::half_bank_size)
					hi_banks[slot] <= raw_bank + 7'd1;
			end else begin
				hi_banks[slot] <= raw_bank;	// ROMH only packet
			end
		end
	end

	// Lookup ports
	assign sel_lo    = lo_banks[sel_bank];
	assign sel_hi    = hi_banks[sel_bank];
	assign lo_entry0 = lo_banks[0];
	assign hi_entry0 = hi_banks[0];

endmodule

// File: cart_mapper_ctrl.sv
// Mapper control: per cartridge type banking registers, IO1/IO2 edge strobes and EXROM/GAME lines
`timescale 1ns/10ps

module cart_mapper_ctrl (
	input  logic                        clk32,
	input  logic                        reset_n,	// Synchronous, active high
	input  logic                        ioe,		// IO1, $DExx
	input  logic                        iof,		// IO2, $DFxx
	input  logic                        rom_l,
	input  logic                        mem_write,
	input  cart_pkg::cart_type_e        cart_id,
	input  logic [7:0]                  cart_exrom,	// CRT header EXROM
	input  logic [7:0]                  cart_game,	// CRT header GAME
	input  logic [7:0]                  data_in,
	input  logic [15:0]                 addr_in,
	input  logic [cart_pkg::bank_w-1:0] lo_entry0,
	input  logic [cart_pkg::bank_w-1:0] hi_entry0,
	input  logic [cart_pkg::bank_w-1:0] sel_lo,
	input  logic [cart_pkg::bank_w-1:0] sel_hi,
	output logic [cart_pkg::sel_w-1:0]  sel_bank,
	output logic [cart_pkg::bank_w-1:0] bank_lo,
	output logic [cart_pkg::bank_w-1:0] bank_hi,
	output logic [cart_pkg::bank_w-1:0] ioe_bank,
	output logic [cart_pkg::bank_w-1:0] iof_bank,
	output logic                        ioe_ena,
	output logic                        iof_ena,
	output logic                        ioe_wr_ena,
	output logic                        iof_wr_ena,
	output logic                        exrom_ov,
	output logic                        game_ov,
	output logic                        stb_ioe,
	output logic                        stb_iof
);

	logic old_ioe;
	logic old_iof;
	logic ioe_wr;
	logic ioe_rd;
	logic init_pend;				// First cycle after a reset
	cart_pkg::cart_type_e old_id;
	logic [cart_pkg::epyx_cnt_w-1:0] epyx_cnt;
	logic epyx_cnt_ena;

	// **********************************************************************
	// IO window access strobes
	// **********************************************************************

	always_ff @(posedge clk32) begin
		if (reset_n) begin
			old_ioe <= 1'b0;
			old_iof <= 1'b0;
		end else begin
			old_ioe <= ioe;
			old_iof <= iof;
		end
	end

	assign stb_ioe = ioe && !old_ioe;	// First cycle of the access
	assign stb_iof = iof && !old_iof;
	assign ioe_wr  = stb_ioe && mem_write;
	assign ioe_rd  = stb_ioe && !mem_write;

	// EasyFlash bank register selects the table entry
	assign sel_bank = data_in[cart_pkg::sel_w-1:0];

	// **********************************************************************
	// Banking registers
	// **********************************************************************

	always_ff @(posedge clk32) begin
		old_id    <= cart_id;
		init_pend <= 1'b0;

		if (reset_n || (cart_id != old_id)) begin
			// No cartridge until the type has settled
			exrom_ov     <= 1'b1;
			game_ov      <= 1'b1;
			bank_lo      <= '0;
			bank_hi      <= '0;
			ioe_bank     <= '0;
			iof_bank     <= '0;
			ioe_ena      <= 1'b0;
			iof_ena      <= 1'b0;
			ioe_wr_ena   <= 1'b0;
			iof_wr_ena   <= 1'b0;
			epyx_cnt     <= '0;
			epyx_cnt_ena <= 1'b0;
			init_pend    <= 1'b1;
		end else begin
			case (cart_id)
				// 8K, 16K or ultimax straight from the header
				cart_pkg::generic: begin
					exrom_ov <= cart_exrom[0];
					game_ov  <= cart_game[0];
					bank_lo  <= lo_entry0;
					bank_hi  <= hi_entry0;
				end

				// Read of IO1 gives 8K config, write gives 16K
				cart_pkg::simons_basic: begin
					if (init_pend) begin
						exrom_ov <= 1'b0;
						game_ov  <= 1'b0;
						bank_lo  <= 7'd0;
						bank_hi  <= 7'd1;
					end
					if (ioe_wr)
						game_ov <= 1'b0;
					if (ioe_rd)
						game_ov <= 1'b1;
				end

				// Same bank mirrored at $8000 and $A000
				cart_pkg::ocean1: begin
					exrom_ov <= 1'b0;
					game_ov  <= 1'b0;
					if (ioe_wr) begin
						bank_lo <= {1'b0, data_in[5:0]};
						bank_hi <= {1'b0, data_in[5:0]};
					end
				end

				cart_pkg::epyx_fastload: begin
					if (ioe || rom_l)
						epyx_cnt_ena <= 1'b1;

					// Any access charges the capacitor again
					if (init_pend || ioe || rom_l) begin
						game_ov  <= 1'b1;
						exrom_ov <= 1'b0;
						epyx_cnt <= cart_pkg::epyx_cnt_w'(cart_pkg::epyx_hold_cycles);
						iof_ena  <= 1'b1;		// Last ROM page readable at $DFxx
						iof_bank <= 7'd0;
					end else if (epyx_cnt_ena) begin
						if (epyx_cnt != '0)
							epyx_cnt <= epyx_cnt - 1'b1;
						else
							exrom_ov <= 1'b1;	// Discharged, cartridge off
					end
				end

				// Bank from the IO1 address, read goes back to bank 0
				cart_pkg::c64gs: begin
					game_ov  <= 1'b1;
					exrom_ov <= 1'b0;
					if (ioe_rd)
						bank_lo <= 7'd0;
					if (ioe_wr)
						bank_lo <= {1'b0, addr_in[5:0]};
				end

				cart_pkg::magic_desk: begin
					if (init_pend) begin
						game_ov  <= 1'b1;
						exrom_ov <= 1'b0;
						bank_lo  <= 7'd0;
					end
					if (ioe_wr) begin
						bank_lo  <= {3'b000, data_in[3:0]};
						exrom_ov <= data_in[7];		// Bit 7 switches the cartridge off
					end
				end

				// $DE00 bank, $DE02 control, 256 bytes RAM at $DFxx
				cart_pkg::easyflash,
				cart_pkg::easyflash_xbank: begin
					if (init_pend) begin
						iof_bank   <= 7'd0;
						iof_ena    <= 1'b1;
						iof_wr_ena <= 1'b1;
						exrom_ov   <= (cart_id == cart_pkg::easyflash);	// Boots ultimax
						game_ov    <= 1'b0;
						bank_lo    <= lo_entry0;
						bank_hi    <= hi_entry0;
					end
					if (ioe_wr) begin
						if (addr_in[1]) begin
							game_ov  <= !data_in[0] && data_in[2];	// Jumper assumed in boot position
							exrom_ov <= !data_in[1];
						end else begin
							bank_lo <= sel_lo;
							bank_hi <= sel_hi;
						end
					end
				end

				default: ;		// Unknown type, lines stay released
			endcase
		end
	end

endmodule

// File: cart_pkg.sv
// Shared cartridge types, widths and memory map constants; referenced by scoped name from the RTL
package cart_pkg;

	// **********************************************************************
	// Cartridge types handled by the mapper
	// **********************************************************************

	// CRT header hardware type; ids not listed here leave the cartridge idle
	typedef enum logic [15:0] {
		generic         = 16'd0,
		simons_basic    = 16'd4,
		ocean1          = 16'd5,
		epyx_fastload   = 16'd10,
		c64gs           = 16'd15,
		magic_desk      = 16'd19,
		easyflash       = 16'd32,
		easyflash_xbank = 16'd33	// XBank looks the same as EasyFlash
	} cart_type_e;

	// **********************************************************************
	// Widths
	// **********************************************************************

	localparam int bank_w       = 7;		// Bank number
	localparam int table_depth  = 64;		// Chip packets held by the bank table
	localparam int sel_w        = $clog2(table_depth);
	localparam int sdram_addr_w = 25;		// SDRAM byte address
	localparam int sdram_bank_w = sdram_addr_w - 13;	// 8 KB bank field, bits 24..13

	// **********************************************************************
	// SDRAM layout, in units of the 8 KB bank field
	// **********************************************************************

	// ROM banks start at 0x100000, up to 1 MB
	localparam logic [sdram_bank_w-1:0] rom_region_bit  = 12'h080;
	// RAM banks start at 0x010000, 64 KB at most
	localparam logic [sdram_bank_w-1:0] ram_region_base = 12'h008;

	// CRT chip packet loading
	localparam logic [15:0] low_load_limit = 16'h8000;	// ROML side up to here
	localparam logic [15:0] half_bank_size = 16'h2000;	// 16 KB packets fill both halves

	// Epyx Fastload capacitor model
	localparam int epyx_hold_cycles = 16384;
	localparam int epyx_cnt_w       = $clog2(epyx_hold_cycles + 1);

endpackage

// File: cartridge.sv
// Cartridge mapper top level: bank table, mapper control and address translation for CRT images
`timescale 1ns/10ps

module cartridge (
	input  logic                              clk32,
	input  logic                              reset_n,	// Synchronous, active high

	// **********************************************************************
	// CRT loader
	// **********************************************************************
	input  logic                              cart_loading,
	input  logic [15:0]                       cart_id,		// CRT hardware type
	input  logic [7:0]                        cart_exrom,
	input  logic [7:0]                        cart_game,
	input  logic [15:0]                       cart_bank_laddr,	// Packet load address
	input  logic [15:0]                       cart_bank_size,
	input  logic [15:0]                       cart_bank_num,
	input  logic [cart_pkg::sdram_addr_w-1:0] cart_bank_raddr,	// Packet location in SDRAM
	input  logic                              cart_bank_wr,

	// **********************************************************************
	// Expansion port and CPU bus
	// **********************************************************************
	output logic                              exrom,
	output logic                              game,
	input  logic                              rom_l,
	input  logic                              rom_h,
	input  logic                              ioe,
	input  logic                              iof,
	input  logic                              mem_write,
	input  logic                              mem_ce,
	output logic                              mem_ce_out,
	output logic                              mem_write_out,
	input  logic [15:0]                       addr_in,
	input  logic [7:0]                        data_in,
	output logic [cart_pkg::sdram_addr_w-1:0] addr_out,
	output logic [cart_pkg::bank_w-1:0]       bank_lo,
	output logic [cart_pkg::bank_w-1:0]       bank_hi
);

	logic [cart_pkg::sel_w-1:0]  sel_bank;
	logic [cart_pkg::bank_w-1:0] sel_lo;
	logic [cart_pkg::bank_w-1:0] sel_hi;
	logic [cart_pkg::bank_w-1:0] lo_entry0;
	logic [cart_pkg::bank_w-1:0] hi_entry0;
	logic [cart_pkg::bank_w-1:0] ioe_bank;
	logic [cart_pkg::bank_w-1:0] iof_bank;
	logic ioe_ena;
	logic iof_ena;
	logic ioe_wr_ena;
	logic iof_wr_ena;
	logic exrom_ov;
	logic game_ov;
	logic stb_ioe;
	logic stb_iof;

	assign exrom = exrom_ov;
	assign game  = game_ov;

	cart_bank_table bank_table_i (
		.clk32           (clk32),
		.cart_loading    (cart_loading),
		.cart_bank_wr    (cart_bank_wr),
		.cart_bank_laddr (cart_bank_laddr),
		.cart_bank_size  (cart_bank_size),
		.cart_bank_num   (cart_bank_num),
		.cart_bank_raddr (cart_bank_raddr),
		.sel_bank        (sel_bank),
		.sel_lo          (sel_lo),
		.sel_hi          (sel_hi),
		.lo_entry0       (lo_entry0),
		.hi_entry0       (hi_entry0)
	);

	// Any id is legal here, unknown ones just leave the lines released
	cart_mapper_ctrl mapper_ctrl_i (
		.clk32      (clk32),
		.reset_n    (reset_n),
		.ioe        (ioe),
		.iof        (iof),
		.rom_l      (rom_l),
		.mem_write  (mem_write),
		.cart_id    (cart_pkg::cart_type_e'(cart_id)),
		.cart_exrom (cart_exrom),
		.cart_game  (cart_game),
		.data_in    (data_in),
		.addr_in    (addr_in),
		.lo_entry0  (lo_entry0),
		.hi_entry0  (hi_entry0),
		.sel_lo     (sel_lo),
		.sel_hi     (sel_hi),
		.sel_bank   (sel_bank),
		.bank_lo    (bank_lo),
		.bank_hi    (bank_hi),
		.ioe_bank   (ioe_bank),
		.iof_bank   (iof_bank),
		.ioe_ena    (ioe_ena),
		.iof_ena    (iof_ena),
		.ioe_wr_ena (ioe_wr_ena),
		.iof_wr_ena (iof_wr_ena),
		.exrom_ov   (exrom_ov),
		.game_ov    (game_ov),
		.stb_ioe    (stb_ioe),
		.stb_iof    (stb_iof)
	);

	cart_addr_xlate addr_xlate_i (
		.reset_n       (reset_n),
		.rom_l         (rom_l),
		.rom_h         (rom_h),
		.ioe           (ioe),
		.iof           (iof),
		.mem_write     (mem_write),
		.mem_ce        (mem_ce),
		.stb_ioe       (stb_ioe),
		.stb_iof       (stb_iof),
		.ioe_ena       (ioe_ena),
		.iof_ena       (iof_ena),
		.ioe_wr_ena    (ioe_wr_ena),
		.iof_wr_ena    (iof_wr_ena),
		.exrom_ov      (exrom_ov),
		.game_ov       (game_ov),
		.addr_in       (addr_in),
		.bank_lo       (bank_lo),
		.bank_hi       (bank_hi),
		.ioe_bank      (ioe_bank),
		.iof_bank      (iof_bank),
		.addr_out      (addr_out),
		.mem_ce_out    (mem_ce_out),
		.mem_write_out (mem_write_out)
	);

endmodule

// File: cartridge_asserts.sv
// Concurrent checks of the EXROM/GAME and write protection rules, bound into the cartridge top
`timescale 1ns/10ps

module cartridge_asserts (
	input logic        clk32,
	input logic        reset_n,
	input logic [15:0] cart_id,
	input logic        exrom,
	input logic        game,
	input logic        rom_l,
	input logic        mem_write,
	input logic        mem_write_out
);

	int fail_cnt = 0;	// Failed checks so far

	// **********************************************************************
	// EXROM and GAME lines
	// **********************************************************************

	// A type change counts as a reset
	property lines_released_after_reset;
		@(posedge clk32) (reset_n || (cart_id != $past(cart_id))) |=> (exrom && game);
	endproperty

	// Settled Ocean type 1 always runs in 16K mode
	property ocean1_lines_low;
		@(posedge clk32)
			($past(cart_id) == cart_pkg::ocean1 && $past(cart_id, 2) == cart_pkg::ocean1
				&& !$past(reset_n)) |-> (!exrom && !game);
	endproperty

	// **********************************************************************
	// Write enable to SDRAM
	// **********************************************************************

	property ultimax_roml_write_blocked;
		@(posedge clk32) (rom_l && mem_write && exrom && !game) |-> !mem_write_out;
	endproperty

	property plain_write_passes;
		@(posedge clk32) (mem_write && !rom_l) |-> mem_write_out;
	endproperty

	reset_release_check: assert property (lines_released_after_reset)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("EXROM or GAME not released one cycle after a reset");
	end

	ocean1_check: assert property (ocean1_lines_low)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("Ocean type 1 selected but EXROM or GAME is high");
	end

	ultimax_check: assert property (ultimax_roml_write_blocked)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("ROML write reached SDRAM in ultimax mode");
	end

	write_pass_check: assert property (plain_write_passes)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("CPU write outside ROML was blocked");
	end

endmodule

bind cartridge cartridge_asserts cartridge_asserts_i (
	.clk32         (clk32),
	.reset_n       (reset_n),
	.cart_id       (cart_id),
	.exrom         (exrom),
	.game          (game),
	.rom_l         (rom_l),
	.mem_write     (mem_write),
	.mem_write_out (mem_write_out)
);

// File: tb_cartridge.sv
// Testbench for the cartridge mapper: loads a CRT image, then walks each cartridge type on the DUT
`timescale 1ns/10ps

module tb_cartridge;

	localparam int period = 100;
	// Epyx discharge dominates, every other scenario takes a few dozen cycles
	localparam int scenario_cycles = cart_pkg::epyx_hold_cycles + 300;
	localparam longint watchdog_ns = longint'(scenario_cycles) * period * 5 / 4;

	logic        clk32 = 1'b0;
	logic        reset_n;
	logic        cart_loading;
	logic [15:0] cart_id;
	logic [7:0]  cart_exrom;
	logic [7:0]  cart_game;
	logic [15:0] cart_bank_laddr;
	logic [15:0] cart_bank_size;
	logic [15:0] cart_bank_num;
	logic [24:0] cart_bank_raddr;
	logic        cart_bank_wr;
	logic        rom_l;
	logic        rom_h;
	logic        ioe;
	logic        iof;
	logic        mem_write;
	logic        mem_ce;
	logic [15:0] addr_in;
	logic [7:0]  data_in;
	logic        exrom;
	logic        game;
	logic        mem_ce_out;
	logic        mem_write_out;
	logic [24:0] addr_out;
	logic [6:0]  bank_lo;
	logic [6:0]  bank_hi;

	logic [31:0] rng;
	logic [6:0]  bank_b;		// Raw bank of packet 0
	logic [6:0]  bank_c;		// Raw bank of packet k
	logic [5:0]  pkt_k;
	logic [7:0]  val;
	int          n;

	cartridge cartridge_i (
		.clk32           (clk32),
		.reset_n         (reset_n),
		.cart_loading    (cart_loading),
		.cart_id         (cart_id),
		.cart_exrom      (cart_exrom),
		.cart_game       (cart_game),
		.cart_bank_laddr (cart_bank_laddr),
		.cart_bank_size  (cart_bank_size),
		.cart_bank_num   (cart_bank_num),
		.cart_bank_raddr (cart_bank_raddr),
		.cart_bank_wr    (cart_bank_wr),
		.exrom           (exrom),
		.game            (game),
		.rom_l           (rom_l),
		.rom_h           (rom_h),
		.ioe             (ioe),
		.iof             (iof),
		.mem_write       (mem_write),
		.mem_ce          (mem_ce),
		.mem_ce_out      (mem_ce_out),
		.mem_write_out   (mem_write_out),
		.addr_in         (addr_in),
		.data_in         (data_in),
		.addr_out        (addr_out),
		.bank_lo         (bank_lo),
		.bank_hi         (bank_hi)
	);

	always #(period / 2) clk32 = ~clk32;

	// **********************************************************************
	// Helpers
	// **********************************************************************

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ROM banks sit at 1 MB, 8 KB each
	function automatic logic [24:0] rom_addr(input logic [6:0] bank, input logic [15:0] cpu_addr);
		return 25'h100000 + {bank, 13'h0000} + cpu_addr[12:0];
	endfunction

	// RAM banks at 64 KB, only eight of them
	function automatic logic [24:0] ram_addr(input logic [6:0] bank, input logic [15:0] cpu_addr);
		return 25'h010000 + {bank[2:0], 13'h0000} + cpu_addr[12:0];
	endfunction

	task automatic stop_with_failure();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected === actual)
		else begin
			$display("Error: %s expected 0x%0h actual 0x%0h", test, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk32);
		#10;
	endtask

	task automatic select_type(input logic [15:0] id);
		cart_id = id;
		repeat (2) next_cycle();	// Defaults at the change edge, start-up values one edge later
	endtask

	task automatic load_packet(input logic [5:0] num, input logic [6:0] raw,
		input logic [15:0] laddr, input logic [15:0] size);
		cart_bank_num   = {10'd0, num};
		cart_bank_raddr = 25'h100000 | {raw, 13'h0000};
		cart_bank_laddr = laddr;
		cart_bank_size  = size;
		cart_bank_wr    = 1'b1;
		next_cycle();
		cart_bank_wr    = 1'b0;
	endtask

	// IO1 low over one edge first, so the access raises a fresh strobe
	task automatic io1_access(input logic wr, input logic [15:0] addr, input logic [7:0] data);
		next_cycle();
		ioe       = 1'b1;
		mem_write = wr;
		addr_in   = addr;
		data_in   = data;
		next_cycle();
		ioe       = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic rom_read(input string test, input logic lo, input logic [15:0] addr,
		input logic [24:0] expected);
		rom_l   = lo;
		rom_h   = !lo;
		addr_in = addr;
		#1;
		check_value(test, expected, addr_out);
		rom_l = 1'b0;
		rom_h = 1'b0;
	endtask

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired before the scenarios completed");
		stop_with_failure();
	end

	always @(posedge clk32) begin
		if (cartridge_i.cartridge_asserts_i.fail_cnt != 0) begin
			$display("A bound assertion on the cartridge failed");
			stop_with_failure();
		end
	end

	// **********************************************************************
	// Scenarios
	// **********************************************************************

	initial begin
		reset_n         = 1'b1;
		cart_loading    = 1'b0;
		cart_id         = 16'hFFFF;		// No cartridge
		cart_exrom      = 8'd1;
		cart_game       = 8'd1;
		cart_bank_laddr = 16'h0000;
		cart_bank_size  = 16'h0000;
		cart_bank_num   = 16'h0000;
		cart_bank_raddr = '0;
		cart_bank_wr    = 1'b0;
		rom_l           = 1'b0;
		rom_h           = 1'b0;
		ioe             = 1'b0;
		iof             = 1'b0;
		mem_write       = 1'b0;
		mem_ce          = 1'b0;
		addr_in         = 16'h0000;
		data_in         = 8'h00;
		rng             = 32'd14;
		repeat (2) next_cycle();
		reset_n = 1'b0;

		// Bank table load and generic type
		rng    = xorshift(rng);
		bank_b = {1'b0, rng[5:0]};
		rng    = xorshift(rng);
		bank_c = {1'b0, bank_b[5:0] ^ (rng[5:0] | 6'd1)};	// Never equal to bank_b
		rng    = xorshift(rng);
		pkt_k  = rng[5:0] | 6'd1;	// Never packet 0
		cart_loading = 1'b1;
		next_cycle();
		load_packet(6'd0, bank_b, 16'h8000, 16'h4000);
		load_packet(pkt_k, bank_c, 16'h8000, 16'h4000);
		cart_loading = 1'b0;
		rng        = xorshift(rng);
		cart_exrom = {7'd0, rng[0]};
		cart_game  = {7'd0, rng[1]};
		select_type(cart_pkg::generic);
		check_value("generic exrom", cart_exrom[0], exrom);
		check_value("generic game", cart_game[0], game);
		rom_read("generic roml", 1'b1, 16'h8123, rom_addr(bank_b, 16'h8123));
		rom_read("generic romh", 1'b0, 16'hA456, rom_addr(bank_b + 7'd1, 16'hA456));

		// Ocean type 1
		select_type(cart_pkg::ocean1);
		rng = xorshift(rng);
		val = rng[7:0];
		io1_access(1'b1, 16'hDE00, val);
		rom_read("ocean1 roml", 1'b1, 16'h8010, rom_addr({1'b0, val[5:0]}, 16'h8010));
		rom_read("ocean1 romh", 1'b0, 16'hA010, rom_addr({1'b0, val[5:0]}, 16'hA010));

		// Magic Desk, then C64GS
		select_type(cart_pkg::magic_desk);
		check_value("magic desk start exrom", 0, exrom);
		rng = xorshift(rng);
		val = {4'b1000, rng[3:0]};
		io1_access(1'b1, 16'hDE00, val);
		check_value("magic desk exrom off", 1, exrom);
		check_value("magic desk bank", val[3:0], bank_lo);
		select_type(cart_pkg::c64gs);
		rng = xorshift(rng);
		val = {2'b00, rng[5:0] | 6'd1};
		io1_access(1'b1, 16'hDE00 | {10'd0, val[5:0]}, 8'h00);
		check_value("c64gs bank from address", val[5:0], bank_lo);
		io1_access(1'b0, 16'hDE00, 8'h00);
		check_value("c64gs bank after read", 0, bank_lo);

		// EasyFlash boots in ultimax
		select_type(cart_pkg::easyflash);
		check_value("easyflash boot exrom", 1, exrom);
		check_value("easyflash boot game", 0, game);
		check_value("easyflash boot bank_hi", bank_b + 7'd1, bank_hi);
		rom_l     = 1'b1;
		mem_write = 1'b1;
		addr_in   = 16'h8000;
		#1;
		check_value("ultimax roml write", 0, mem_write_out);
		next_cycle();			// Held over an edge for the bound check
		rom_l     = 1'b0;
		mem_write = 1'b0;
		io1_access(1'b1, 16'hDE00, {2'b00, pkt_k});
		check_value("easyflash bank_lo", bank_c, bank_lo);
		check_value("easyflash bank_hi", bank_c + 7'd1, bank_hi);
		rom_read("easyflash roml", 1'b1, 16'h9ABC, rom_addr(bank_c, 16'h9ABC));
		// Bits 2 and 1 set so both lines leave their boot levels
		val = 8'h06;
		io1_access(1'b1, 16'hDE02, val);
		check_value("easyflash game", 1, game);
		check_value("easyflash exrom", 0, exrom);
		iof       = 1'b1;
		mem_write = 1'b1;
		addr_in   = 16'hDF42;
		#1;
		check_value("easyflash io2 ce", 1, mem_ce_out);
		check_value("easyflash io2 addr", ram_addr(7'd0, 16'hDF42), addr_out);
		iof       = 1'b0;
		mem_write = 1'b0;

		// Epyx Fastload
		select_type(cart_pkg::epyx_fastload);
		iof     = 1'b1;
		addr_in = 16'hDF10;
		#1;
		check_value("epyx io2 addr", rom_addr(7'd0, 16'hDF10), addr_out);
		iof = 1'b0;
		io1_access(1'b0, 16'hDE00, 8'h00);
		n = 0;
		while (exrom !== 1'b1 && n <= 2 * cart_pkg::epyx_hold_cycles) begin
			check_value("epyx game held", 1, game);
			next_cycle();
			n++;
		end
		// Reloaded at the access edge, counts down to zero, releases one edge later
		check_value("epyx hold cycles", cart_pkg::epyx_hold_cycles + 1, n);

		// Reset and type change release the lines, both start from 16K mode
		select_type(cart_pkg::ocean1);
		reset_n = 1'b1;
		next_cycle();
		reset_n = 1'b0;
		check_value("reset exrom", 1, exrom);
		check_value("reset game", 1, game);
		next_cycle();
		cart_id = cart_pkg::magic_desk;
		next_cycle();
		check_value("type change exrom", 1, exrom);
		check_value("type change game", 1, game);
		next_cycle();
		check_value("magic desk exrom after change", 0, exrom);
		next_cycle();

		if (cartridge_i.cartridge_asserts_i.fail_cnt == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("Bound assertions reported failures");
			stop_with_failure();
		end
	end

endmodule
